//--- files.f
+incdir+tb
logic/rob_pkg.sv
logic/rob_ptr_counter.sv
logic/rob_table.sv
logic/commit_fsm.sv
logic/rob_top.sv
tb/tb_rob_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_rob_top -f files.f

./obj_dir/Vtb_rob_top > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
exit 1

//--- tb/tb_rob_checks.svh
// dispatch fields plus the outcome reported at completion
typedef struct packed {
    dispatch_t d;
    logic      taken;
    addr_t     target;
} stim_row_t;

typedef struct packed {
    commit_t   c;
    logic      redir;
    redirect_t r;
} expect_t;

localparam int num_cases   = 7;
localparam int mode_random = 0;
localparam int mode_last   = 1;
localparam int mode_stall  = 2;
localparam int mode_fill   = 3;

stim_row_t table_rows [64];
tag_t      row_tag [64];
int        case_first [num_cases];
int        case_count [num_cases];
int        case_mode [num_cases];
int        total_rows;
int        cases_loaded;
int        expected_total;
expect_t   exp_q [$];

function automatic void add_row(addr_t pc, int rd, logic is_branch, logic predict,
                                addr_t predict_target, logic taken, addr_t target);
    stim_row_t r;
    r.d.pc             = pc;
    r.d.rd             = areg_t'(rd);
    r.d.pd             = preg_t'(rd + 32);
    r.d.pd_old         = preg_t'(rd);
    r.d.reg_wr         = (rd != 0);
    r.d.is_branch      = is_branch;
    r.d.predict        = predict;
    r.d.predict_target = predict_target;
    r.taken            = taken;
    r.target           = target;
    table_rows[total_rows] = r;
    total_rows++;
    case_count[cases_loaded - 1]++;
endfunction

function automatic void start_case(int mode);
    case_first[cases_loaded] = total_rows;
    case_count[cases_loaded] = 0;
    case_mode[cases_loaded]  = mode;
    cases_loaded++;
endfunction

function automatic void load_table();
    total_rows   = 0;
    cases_loaded = 0;
    // plain alu ops
    start_case(mode_random);
    for (int i = 0; i < 6; i++) begin
        add_row(addr_t'(32'h1000 + 4 * i), i + 1, 1'b0, 1'b0, '0, 1'b0, '0);
    end
    start_case(mode_last);
    for (int i = 0; i < 5; i++) begin
        add_row(addr_t'(32'h2000 + 4 * i), i + 8, 1'b0, 1'b0, '0, 1'b0, '0);
    end
    // predicted taken, falls through
    start_case(mode_random);
    add_row(32'h3000, 3, 1'b0, 1'b0, '0, 1'b0, '0);
    add_row(32'h3004, 4, 1'b0, 1'b0, '0, 1'b0, '0);
    add_row(32'h3008, 0, 1'b1, 1'b1, 32'h3100, 1'b0, 32'h3100);
    add_row(32'h300c, 5, 1'b0, 1'b0, '0, 1'b0, '0);
    add_row(32'h3010, 6, 1'b0, 1'b0, '0, 1'b0, '0);
    // predicted not taken, goes to 0x4800
    start_case(mode_random);
    add_row(32'h4000, 7, 1'b0, 1'b0, '0, 1'b0, '0);
    add_row(32'h4004, 0, 1'b1, 1'b0, '0, 1'b1, 32'h4800);
    add_row(32'h4008, 9, 1'b0, 1'b0, '0, 1'b0, '0);
    // good predictions, jump included, then a wrong target
    start_case(mode_random);
    add_row(32'h5000, 0, 1'b1, 1'b1, 32'h5040, 1'b1, 32'h5040);
    add_row(32'h5040, 0, 1'b1, 1'b0, '0, 1'b0, '0);
    add_row(32'h5044, 1, 1'b0, 1'b1, 32'h5200, 1'b1, 32'h5200);
    add_row(32'h5200, 0, 1'b1, 1'b1, 32'h5300, 1'b1, 32'h5380);
    add_row(32'h5204, 2, 1'b0, 1'b0, '0, 1'b0, '0);
    start_case(mode_stall);
    for (int i = 0; i < 4; i++) begin
        add_row(addr_t'(32'h6000 + 4 * i), i + 20, 1'b0, 1'b0, '0, 1'b0, '0);
    end
    // one more row than the buffer holds
    start_case(mode_fill);
    for (int i = 0; i < depth + 1; i++) begin
        add_row(addr_t'(32'h7000 + 4 * i), (i % 31) + 1, 1'b0, 1'b0, '0, 1'b0, '0);
    end
endfunction

function automatic logic predicts_wrong(stim_row_t r);
    if (r.d.is_branch && (r.taken != r.d.predict)) begin
        return 1'b1;
    end
    return r.taken && r.d.predict && (r.target != r.d.predict_target);
endfunction

// queues the commits of a case, nothing younger than a mispredict retires
function automatic logic queue_expected(int first, int count);
    expect_t e;
    for (int i = first; i < first + count; i++) begin
        e.c.pc     = table_rows[i].d.pc;
        e.c.rd     = table_rows[i].d.rd;
        e.c.pd     = table_rows[i].d.pd;
        e.c.pd_old = table_rows[i].d.pd_old;
        e.c.reg_wr = table_rows[i].d.reg_wr;
        e.redir    = predicts_wrong(table_rows[i]);
        e.r.pc     = table_rows[i].taken ? table_rows[i].target : table_rows[i].d.pc + 32'd4;
        exp_q.push_back(e);
        expected_total++;
        if (e.redir) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

task automatic check_commit(commit_t got, commit_t exp);
    if (got !== exp) begin
        $display("FAILED commit: got %h, expected %h", got, exp);
        stop_on_error();
    end
endtask

task automatic check_redirect(redirect_t got, redirect_t exp);
    if (got !== exp) begin
        $display("FAILED redirect.pc: got %h, expected %h", got.pc, exp.pc);
        stop_on_error();
    end
endtask

task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h, expected %h", name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_tag(tag_t got, tag_t exp);
    if (got !== exp) begin
        $display("FAILED dispatch_tag: got %h, expected %h", got, exp);
        stop_on_error();
    end
endtask

//--- tb/tb_rob_top.sv
`timescale 1ns/10ps

module tb_rob_top import rob_pkg::*; ();

    localparam int depth = rob_depth_default;
    localparam int tag_w = $clog2(depth);
    typedef logic [tag_w-1:0] tag_t;

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    tag_t      dispatch_tag;
    logic      full;
    logic      complete_valid;
    tag_t      complete_tag;
    result_t   complete;
    logic      commit_stall;
    logic      commit_valid;
    commit_t   commit;
    logic      redirect_valid;
    redirect_t redirect;

    tag_t model_tail;
    int   cycle = 0;
    int   commit_count = 0;
    int   commit_cycle_q [$];

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1);
    endtask

    `include "tb_rob_checks.svh"

    rob_top #(.depth(depth)) u_dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .full           (full),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .complete       (complete),
        .commit_stall   (commit_stall),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = total_rows * 40 + 2000;
        repeat (limit) @(posedge clk);
        $display("timeout: the run was still going after %0d cycles", limit);
        stop_on_error();
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin : commit_monitor
        expect_t e;
        if (!rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("commit of pc %h arrived with no commit outstanding", commit.pc);
                stop_on_error();
            end
            e = exp_q.pop_front();
            check_commit(commit, e.c);
            check_flag("redirect_valid", redirect_valid, e.redir);
            if (e.redir) begin
                check_redirect(redirect, e.r);
            end
            commit_count++;
            commit_cycle_q.push_back(cycle);
        end else if (!rst) begin
            check_flag("redirect_valid", redirect_valid, 1'b0);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // holds the row on the port until the DUT takes it
    task automatic dispatch_row(int idx);
        logic accepted;
        accepted       = 1'b0;
        dispatch_valid = 1'b1;
        dispatch       = table_rows[idx].d;
        while (!accepted) begin
            if (dispatch_ready) begin
                check_tag(dispatch_tag, model_tail);
                row_tag[idx] = dispatch_tag;
                model_tail   = tag_t'(model_tail + 1);
                accepted     = 1'b1;
            end
            next_cycle();
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic complete_row(int idx);
        complete_valid  = 1'b1;
        complete_tag    = row_tag[idx];
        complete.taken  = table_rows[idx].taken;
        complete.target = table_rows[idx].target;
        next_cycle();
        complete_valid = 1'b0;
    endtask

    task automatic complete_shuffled(int first, int count, int skip);
        int order [$];
        int j;
        int tmp;
        for (int i = first; i < first + count; i++) begin
            if (i != skip) begin
                order.push_back(i);
            end
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[k]) begin
            complete_row(order[k]);
            repeat ($urandom % 3) next_cycle();
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
    endtask

    task automatic run_case(int c);
        int   first;
        int   count;
        int   seen;
        int   start;
        int   n;
        logic flushes;
        first   = case_first[c];
        count   = case_count[c];
        flushes = queue_expected(first, count);
        seen    = commit_count;
        if (case_mode[c] == mode_fill) begin
            for (int i = 0; i < depth; i++) begin
                dispatch_row(first + i);
            end
            check_flag("full", full, 1'b1);
            check_flag("dispatch_ready", dispatch_ready, 1'b0);
            fork
                dispatch_row(first + depth);
                begin
                    repeat (3) next_cycle();
                    complete_row(first);
                end
            join
            complete_shuffled(first + 1, count - 1, -1);
        end else begin
            for (int i = 0; i < count; i++) begin
                dispatch_row(first + i);
            end
            if (case_mode[c] == mode_stall) begin
                commit_stall = 1'b1;
            end
            complete_shuffled(first, count, (case_mode[c] == mode_last) ? first : -1);
            repeat (6) next_cycle();
            if (case_mode[c] != mode_random && commit_count != seen) begin
                $display("case %0d: a commit happened before the head could retire", c);
                stop_on_error();
            end
            commit_stall = 1'b0;
            if (case_mode[c] == mode_last) begin
                start = cycle;
                complete_row(first);
            end
        end
        wait_drain();
        if (case_mode[c] == mode_last) begin
            n = commit_cycle_q.size();
            for (int i = 0; i < count; i++) begin
                if (commit_cycle_q[n - count + i] != start + 2 + i) begin
                    $display("case %0d: commit %0d retired in the wrong cycle", c, i);
                    stop_on_error();
                end
            end
        end
        if (flushes) begin
            model_tail = '0;
        end
        check_flag("full", full, 1'b0);
        check_flag("dispatch_ready", dispatch_ready, 1'b1);
    endtask

    initial begin
        void'($urandom(60011));
        load_table();
        expected_total = 0;
        model_tail     = '0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        complete_valid = 1'b0;
        complete_tag   = '0;
        complete       = '0;
        commit_stall   = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();
        check_flag("commit_valid", commit_valid, 1'b0);
        check_flag("redirect_valid", redirect_valid, 1'b0);
        check_flag("dispatch_ready", dispatch_ready, 1'b1);
        check_flag("full", full, 1'b0);
        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end
        if (exp_q.size() == 0 && commit_count == expected_total) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("saw %0d commits where %0d were expected", commit_count, expected_total);
            stop_on_error();
        end
    end

endmodule

//--- logic/rob_top.sv
`timescale 1ns/10ps

module rob_top import rob_pkg::*; #(
    parameter int depth = rob_depth_default,
    localparam int tag_w = $clog2(depth)
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             dispatch_valid,
    input  dispatch_t        dispatch,
    output logic             dispatch_ready,
    output logic [tag_w-1:0] dispatch_tag,
    output logic             full,

    input  logic             complete_valid,
    input  logic [tag_w-1:0] complete_tag,
    input  result_t          complete,

    input  logic             commit_stall,
    output logic             commit_valid,
    output commit_t          commit,
    output logic             redirect_valid,
    output redirect_t        redirect
);

    logic [tag_w-1:0] tail;
    logic [tag_w-1:0] head;
    logic             empty;
    logic             push;
    logic             pop;
    logic             flush;
    logic             complete_wr;
    dispatch_t        head_info;
    result_t          head_result;
    logic             head_done;

    assign dispatch_ready = !full && !flush;
    assign push           = dispatch_valid && dispatch_ready;
    assign dispatch_tag   = tail;

    // results landing during flush belong to squashed entries
    assign complete_wr = complete_valid && !flush;

    rob_ptr_counter #(.depth(depth)) u_ptr (
        .clk            (clk),
        .rst            (rst),
        .push           (push),
        .pop            (pop),
        .clear          (flush),
        .tail           (tail),
        .head           (head),
        .full           (full),
        .empty          (empty)
    );

    rob_table #(.depth(depth), .payload_t(dispatch_t)) u_info_table (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (push),
        .wr_tag         (tail),
        .wr_data        (dispatch),
        .invalidate_en  (1'b0),
        .invalidate_tag ('0),
        .clear_all      (1'b0),
        .rd_tag         (head),
        .rd_data        (head_info),
        .rd_valid       ()
    );

    // valid bit here is the done flag
    rob_table #(.depth(depth), .payload_t(result_t)) u_result_table (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (complete_wr),
        .wr_tag         (complete_tag),
        .wr_data        (complete),
        .invalidate_en  (push),
        .invalidate_tag (tail),
        .clear_all      (flush),
        .rd_tag         (head),
        .rd_data        (head_result),
        .rd_valid       (head_done)
    );

    commit_fsm u_commit (
        .clk            (clk),
        .rst            (rst),
        .head_info      (head_info),
        .head_result    (head_result),
        .head_done      (head_done),
        .empty          (empty),
        .commit_stall   (commit_stall),
        .pop            (pop),
        .flush          (flush),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

endmodule

//--- logic/commit_fsm.sv
`timescale 1ns/10ps

module commit_fsm import rob_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dispatch_t head_info,
    input  result_t   head_result,
    input  logic      head_done,
    input  logic      empty,
    input  logic      commit_stall,
    output logic      pop,
    output logic      flush,
    output logic      commit_valid,
    output commit_t   commit,
    output logic      redirect_valid,
    output redirect_t redirect
);

    commit_state_t state;
    logic          dir_wrong;
    logic          target_wrong;
    logic          mispredict;
    addr_t         redirect_pc;

    // direction miss only matters for branches
    assign dir_wrong = head_info.is_branch && (head_result.taken != head_info.predict);

    // taken as predicted, but somewhere else
    assign target_wrong = head_result.taken && head_info.predict &&
                          (head_result.target != head_info.predict_target);

    assign mispredict = dir_wrong || target_wrong;

    assign redirect_pc = head_result.taken ? head_result.target
                                           : head_info.pc + addr_t'(4);

    // retire the head this cycle
    assign pop   = (state == st_run) && head_done && !empty && !commit_stall;
    assign flush = (state == st_flush);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_run;
        end else begin
            case (state)
                st_run: begin
                    if (pop && mispredict) begin
                        state <= st_flush;
                    end
                end
                // single cycle, pointers and done bits clear on this edge
                st_flush: begin
                    state <= st_run;
                end
                default: begin
                    state <= st_run;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            commit_valid   <= pop;
            redirect_valid <= pop && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            commit.pc     <= head_info.pc;
            commit.rd     <= head_info.rd;
            commit.pd     <= head_info.pd;
            commit.pd_old <= head_info.pd_old;
            commit.reg_wr <= head_info.reg_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && mispredict) begin
            redirect.pc <= redirect_pc;
        end
    end

endmodule

//--- logic/rob_table.sv
`timescale 1ns/10ps

module rob_table import rob_pkg::*; #(
    parameter int depth = rob_depth_default,
    parameter type payload_t = addr_t,
    localparam int tag_w = $clog2(depth)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_en,
    input  logic [tag_w-1:0] wr_tag,
    input  payload_t         wr_data,
    input  logic             invalidate_en,
    input  logic [tag_w-1:0] invalidate_tag,
    input  logic             clear_all,
    input  logic [tag_w-1:0] rd_tag,
    output payload_t         rd_data,
    output logic             rd_valid
);

    payload_t         mem [depth];
    logic [depth-1:0] valid;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_tag] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear_all) begin
            valid <= '0;
        end else begin
            if (wr_en) begin
                valid[wr_tag] <= 1'b1;
            end
            // a freshly allocated entry wins over a stray write
            if (invalidate_en) begin
                valid[invalidate_tag] <= 1'b0;
            end
        end
    end

    assign rd_data  = mem[rd_tag];
    assign rd_valid = valid[rd_tag];

endmodule

//--- logic/rob_ptr_counter.sv
`timescale 1ns/10ps

module rob_ptr_counter import rob_pkg::*; #(
    parameter int depth = rob_depth_default,
    localparam int tag_w = $clog2(depth)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic             pop,
    input  logic             clear,
    output logic [tag_w-1:0] tail,
    output logic [tag_w-1:0] head,
    output logic             full,
    output logic             empty
);

    logic [tag_w:0] count;
    logic           do_push;
    logic           do_pop;

    // never run past either end
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == (tag_w + 1)'(depth));
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            tail <= '0;
            head <= '0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/rob_pkg.sv
package rob_pkg;

    parameter int xlen              = 32;
    parameter int arch_reg_w        = 5;
    parameter int phys_reg_w        = 6;
    parameter int rob_depth_default = 16;

    typedef logic [xlen-1:0]       addr_t;
    typedef logic [phys_reg_w-1:0] preg_t;
    typedef logic [arch_reg_w-1:0] areg_t;

    // static fields captured at dispatch
    typedef struct packed {
        addr_t pc;
        areg_t rd;
        preg_t pd;
        preg_t pd_old;
        logic  reg_wr;
        logic  is_branch;
        logic  predict;
        addr_t predict_target;
    } dispatch_t;

    // what the execution side reports back
    typedef struct packed {
        logic  taken;
        addr_t target;
    } result_t;

    typedef struct packed {
        addr_t pc;
        areg_t rd;
        preg_t pd;
        preg_t pd_old;
        logic  reg_wr;
    } commit_t;

    typedef struct packed {
        addr_t pc;
    } redirect_t;

    typedef enum logic {
        st_run   = 1'b0,
        st_flush = 1'b1
    } commit_state_t;

endpackage
